// ==== sms_host_stim.txt ====
# E vdp pix cpu snd : enable counts expected in one 30-cycle window
# C index(hex) bytes read_addr(hex) mask(hex) gg ; K base flags addr compare replace ; L/S/A sectors
E 6 3 2 15
C 01 16 3fffff 00000f 0
C 02 40 2ab5c3 00003f 1
K 10 13121110 17161514 1b1a1918 1f1e1d1c
L 64
S 64
A 64

// ==== files.f ====
+incdir+.
sms_pkg.sv
sms_clk_enables.sv
sms_cart_loader.sv
sms_cheat_loader.sv
sms_backup_seq.sv
sms_host_top.sv
sms_host_props.sv
tb_sms_host.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the host control testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_sms_host -f files.f -o sim_host
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

out=$(./obj_dir/sim_host)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -q "ALL CHECKS PASSED"; then
	exit 0
fi
exit 1

// ==== tb_sms_host.sv ====
/*
 * Testbench for the host control, driven by sms_host_stim.txt.
 * ROM and SD models answer after pseudo-random delays.
 * Backup tests need a prior cartridge download with a writable image.
 */
`timescale 1ns/1ps
`include "sms_cfg.svh"

module tb_sms_host import sms_pkg::*;;

	logic                   clk_sys = 1'b0;
	logic                   reset;
	host_byte_t             host;
	logic                   download;
	logic                   io_wait;
	rom_wr_t                rom_wr;
	logic                   rom_ack;
	logic [`SMS_ROM_AW-1:0] rom_raddr, rom_raddr_out, cart_mask;
	logic                   gg;
	cheat_code_t            cheat;
	logic                   cheat_valid;
	logic                   img_mounted, img_readonly, img_nonzero;
	logic                   bk_load_level, bk_save_level, autosave, osd_open, nvram_we;
	sd_req_t                sd_req;
	logic                   sd_ack;
	logic                   bk_busy, bk_loading, bk_pending;
	clk_en_t                ce;
	logic                   sys_reset;

	int unsigned            lcg_state = 12734;
	int                     errors = 0;
	int                     tests = 0;
	logic [7:0]             rom_mem [0:255];
	logic [`SMS_ROM_AW-1:0] wr_log [$];
	sd_req_t                sd_log [$];
	logic                   mem_busy;
	int                     mem_delay, sd_phase, sd_delay;

	always #2 clk_sys = ~clk_sys;

	sms_host_top u_dut (.*);

	function automatic int unsigned lcg_next(input int unsigned range);
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return (lcg_state >> 16) % range;
	endfunction

	// Image byte pattern, uses every address bit
	function automatic logic [7:0] cart_byte(input int unsigned a);
		return 8'((a * 37) ^ (a >> 8) ^ 32'h5A);
	endfunction

	task automatic report_mismatch(input string name, input logic [127:0] got,
		input logic [127:0] exp);
		$display("Mismatch at %0t ns: %s got %0h expected %0h", $time, name, got, exp);
		errors++;
	endtask

	task automatic report_bad_line(input string text);
		$display("Malformed stimulus line: %s", text);
		errors++;
	endtask

	task automatic finish_test(input string name, input int e0);
		tests++;
		$display("Test %0d %s: %s", tests, name, (errors == e0) ? "ok" : "errors");
	endtask

	// ========================================================================
	// ROM and SD models
	// ========================================================================
	always @(negedge clk_sys) begin
		if (reset) begin
			rom_ack  = 1'b0;
			mem_busy = 1'b0;
		end else if (!mem_busy && rom_wr.req != rom_ack) begin
			mem_busy  = 1'b1;
			mem_delay = lcg_next(4);
		end else if (mem_busy) begin
			if (mem_delay == 0) begin
				rom_mem[rom_wr.addr[7:0]] = rom_wr.data;
				wr_log.push_back(rom_wr.addr);
				rom_ack  = rom_wr.req;   // Toggle matched
				mem_busy = 1'b0;
			end else
				mem_delay--;
		end
	end

	always @(negedge clk_sys) begin
		if (reset) begin
			sd_ack   = 1'b0;
			sd_phase = 0;
		end else begin
			case (sd_phase)
				0: if (sd_req.rd || sd_req.wr) begin
					sd_delay = lcg_next(6);
					sd_phase = 1;
				end
				1: if (sd_delay == 0) begin
					sd_ack = 1'b1;
					sd_log.push_back(sd_req);
					sd_delay = lcg_next(6);
					sd_phase = 2;
				end else
					sd_delay--;
				2: if (sd_delay == 0) begin
					sd_ack   = 1'b0;
					sd_phase = 3;
				end else
					sd_delay--;
				default: sd_phase = 0;   // Let the next request appear
			endcase
		end
	end

	// ========================================================================
	// Tests
	// ========================================================================
	task automatic test_enables(input int ev, input int ep, input int ec, input int es);
		int e0, nv, np, nc, ns;
		e0 = errors;
		nv = 0;
		np = 0;
		nc = 0;
		ns = 0;
		repeat (`SMS_CE_PERIOD) begin
			@(negedge clk_sys);
			nv += ce.vdp;
			np += ce.pix;
			nc += ce.cpu;
			ns += ce.snd;
			if (ce.cpu && !ce.vdp) begin
				$display("CPU enable without VDP enable at %0t ns", $time);
				errors++;
			end
		end
		if (nv != ev) report_mismatch("ce.vdp count", nv, ev);
		if (np != ep) report_mismatch("ce.pix count", np, ep);
		if (nc != ec) report_mismatch("ce.cpu count", nc, ec);
		if (ns != es) report_mismatch("ce.snd count", ns, es);
		finish_test("clock enables", e0);
	endtask

	task automatic load_cart(input logic [7:0] idx, input int cnt,
		input logic [`SMS_ROM_AW-1:0] raddr, input logic [`SMS_ROM_AW-1:0] mask,
		input int exp_gg);
		int e0, t;
		logic [`SMS_ROM_AW-1:0] run_mask;
		e0 = errors;
		run_mask = '0;
		wr_log.delete();
		@(negedge clk_sys);
		host.index  = idx;
		img_mounted = 1'b1;
		@(negedge clk_sys);
		download = 1'b1;
		for (int a = 0; a < cnt; a++) begin
			@(negedge clk_sys);
			host.wr   = 1'b1;
			host.addr = 25'(a);
			host.data = cart_byte(a);
			@(negedge clk_sys);
			host.wr = 1'b0;
			if (!sys_reset) begin
				$display("sys_reset low during cartridge download at %0t ns", $time);
				errors++;
			end
			// Running mask, a write to address 0 starts it over
			if (a == 0)
				run_mask = '0;
			else
				run_mask = run_mask | `SMS_ROM_AW'(a);
			if (cart_mask != run_mask) report_mismatch("cart_mask", cart_mask, run_mask);
			t = 0;
			while (io_wait && t < 100) begin
				@(negedge clk_sys);
				t++;
			end
			if (io_wait) begin
				$display("Timeout waiting for io_wait to fall at address %0d", a);
				errors++;
			end
		end
		@(negedge clk_sys);
		download = 1'b0;
		if (wr_log.size() != cnt) report_mismatch("ROM write count", wr_log.size(), cnt);
		for (int i = 0; i < wr_log.size(); i++) begin
			if (wr_log[i] != i) report_mismatch("rom_wr.addr", wr_log[i], i);
			if (rom_mem[i] !== cart_byte(i)) report_mismatch("rom_wr.data", rom_mem[i],
				cart_byte(i));
		end
		if (cart_mask != mask) report_mismatch("cart_mask", cart_mask, mask);
		if (gg != exp_gg[0]) report_mismatch("gg", gg, exp_gg);
		rom_raddr = raddr;
		#1;
		if (rom_raddr_out != (raddr & mask))
			report_mismatch("rom_raddr_out", rom_raddr_out, raddr & mask);
		finish_test("cartridge download", e0);
	endtask

	task automatic load_cheat(input logic [7:0] base, input logic [31:0] f,
		input logic [31:0] ad, input logic [31:0] cmp, input logic [31:0] rep);
		int e0, t;
		cheat_code_t got;
		e0 = errors;
		@(negedge clk_sys);
		host.index = `SMS_CODE_INDEX;
		@(negedge clk_sys);
		download = 1'b1;
		for (int a = 0; a < 16; a++) begin
			@(negedge clk_sys);
			host.wr   = 1'b1;
			host.addr = 25'(a);
			host.data = base + 8'(a);
			if (cheat_valid) begin
				$display("cheat_valid before the last byte at %0t ns", $time);
				errors++;
			end
		end
		@(negedge clk_sys);
		host.wr = 1'b0;
		t = 0;
		while (!cheat_valid && t < 10) begin
			@(negedge clk_sys);
			t++;
		end
		got = cheat;
		if (!cheat_valid) begin
			$display("Timeout waiting for cheat_valid");
			errors++;
		end
		@(negedge clk_sys);
		download = 1'b0;
		if (got.flags != f) report_mismatch("cheat.flags", got.flags, f);
		if (got.addr != ad) report_mismatch("cheat.addr", got.addr, ad);
		if (got.compare != cmp) report_mismatch("cheat.compare", got.compare, cmp);
		if (got.replace != rep) report_mismatch("cheat.replace", got.replace, rep);
		finish_test("cheat record", e0);
	endtask

	task automatic run_backup(input byte kind, input int sectors);
		int e0, t;
		bit bad_hold;
		e0 = errors;
		bad_hold = 1'b0;
		sd_log.delete();
		@(negedge clk_sys);
		if (kind == "L") bk_load_level = 1'b1;
		if (kind == "S") bk_save_level = 1'b1;
		if (kind == "A") begin
			nvram_we = 1'b1;
			@(negedge clk_sys);
			nvram_we = 1'b0;
			if (!bk_pending) report_mismatch("bk_pending", bk_pending, 1);
			autosave = 1'b1;
			osd_open = 1'b1;
		end
		t = 0;
		while (!bk_busy && t < 50) begin
			@(negedge clk_sys);
			t++;
		end
		if (!bk_busy) begin
			$display("Timeout waiting for bk_busy to rise");
			errors++;
		end
		t = 0;
		while (bk_busy && t < 20000) begin
			if (kind == "L" && !bad_hold && (!bk_loading || !sys_reset)) begin
				$display("bk_loading or sys_reset low during load at %0t ns", $time);
				errors++;
				bad_hold = 1'b1;
			end
			@(negedge clk_sys);
			t++;
		end
		if (bk_busy) begin
			$display("Timeout waiting for bk_busy to fall");
			errors++;
		end
		bk_load_level = 1'b0;
		bk_save_level = 1'b0;
		autosave      = 1'b0;
		osd_open      = 1'b0;
		@(negedge clk_sys);
		if (bk_pending) report_mismatch("bk_pending", bk_pending, 0);
		if (sd_log.size() != sectors) report_mismatch("sector count", sd_log.size(), sectors);
		for (int i = 0; i < sd_log.size(); i++) begin
			if (sd_log[i].lba != i) report_mismatch("sd_req.lba", sd_log[i].lba, i);
			if (sd_log[i].rd != (kind == "L")) report_mismatch("sd_req.rd", sd_log[i].rd,
				kind == "L");
			if (sd_log[i].wr != (kind != "L")) report_mismatch("sd_req.wr", sd_log[i].wr,
				kind != "L");
		end
		finish_test(kind == "L" ? "backup load" : (kind == "S" ? "backup save" : "autosave"), e0);
	endtask

	// ========================================================================
	// Stimulus file reader
	// ========================================================================
	initial begin
		int fd, n, a0, a1, a2, a3;
		logic [31:0] h0, h1, h2, h3, h4;
		string line;
		byte cmd;
		reset = 1'b1;
		host = '0;
		download = 1'b0;
		rom_ack = 1'b0;
		rom_raddr = '0;
		img_mounted = 1'b0;
		img_readonly = 1'b0;
		img_nonzero = 1'b0;
		bk_load_level = 1'b0;
		bk_save_level = 1'b0;
		autosave = 1'b0;
		osd_open = 1'b0;
		nvram_we = 1'b0;
		sd_ack = 1'b0;
		repeat (4) @(posedge clk_sys);
		@(negedge clk_sys);
		reset = 1'b0;
		fd = $fopen("sms_host_stim.txt", "r");
		if (fd == 0) begin
			$display("Cannot open stimulus file sms_host_stim.txt");
			errors++;
		end else begin
			while (!$feof(fd)) begin
				line = "";
				n = $fgets(line, fd);
				if (line.len() < 2 || line.getc(0) == "#") continue;
				cmd = line.getc(0);
				case (cmd)
					"E": begin
						n = $sscanf(line, "E %d %d %d %d", a0, a1, a2, a3);
						if (n != 4)
							report_bad_line(line);
						else
							test_enables(a0, a1, a2, a3);
					end
					"C": begin
						n = $sscanf(line, "C %h %d %h %h %d", h0, a0, h1, h2, a1);
						if (n != 5)
							report_bad_line(line);
						else
							load_cart(h0[7:0], a0, h1[`SMS_ROM_AW-1:0],
								h2[`SMS_ROM_AW-1:0], a1);
					end
					"K": begin
						n = $sscanf(line, "K %h %h %h %h %h", h0, h1, h2, h3, h4);
						if (n != 5)
							report_bad_line(line);
						else
							load_cheat(h0[7:0], h1, h2, h3, h4);
					end
					"L", "S", "A": begin
						n = $sscanf(line.substr(1, line.len() - 1), "%d", a0);
						if (n != 1)
							report_bad_line(line);
						else
							run_backup(cmd, a0);
					end
					default: begin
						$display("Unknown stimulus command in line: %s", line);
						errors++;
					end
				endcase
			end
			$fclose(fd);
		end
		$display("Tests run: %0d, errors: %0d", tests, errors);
		if (errors == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

// ==== sms_host_props.sv ====
/*
 * Concurrent checks bound into the host control top level.
 * Covers enable reset state, exclusive SD read/write and the cheat pulse width.
 */
`timescale 1ns/1ps

module sms_host_props import sms_pkg::*; (
	input logic    clk_sys,
	input logic    reset,
	input clk_en_t ce,
	input sd_req_t sd_req,
	input logic    cheat_valid
);

	// Registered enables are cleared by reset
	a_ce_reset: assert property (@(posedge clk_sys) reset |=> (ce == '0))
		else $error("clock enables active after a reset cycle");

	a_sd_excl: assert property (@(posedge clk_sys) disable iff (reset)
		!(sd_req.rd && sd_req.wr))
		else $error("SD read and write requested together");

	a_cheat_pulse: assert property (@(posedge clk_sys) disable iff (reset)
		cheat_valid |=> !cheat_valid)
		else $error("cheat_valid high for two cycles");

endmodule

bind sms_host_top sms_host_props u_props (
	.clk_sys     (clk_sys),
	.reset       (reset),
	.ce          (ce),
	.sd_req      (sd_req),
	.cheat_valid (cheat_valid)
);

// ==== sms_host_top.sv ====
/*
 * Host side control of the console core.
 * Index SMS_CODE_INDEX selects a cheat download, any other a cartridge.
 * sys_reset is combinational and holds the core during downloads and loads.
 */
`timescale 1ns/1ps
`include "sms_cfg.svh"

module sms_host_top import sms_pkg::*; (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  host_byte_t             host,
	input  logic                   download,
	output logic                   io_wait,
	output rom_wr_t                rom_wr,
	input  logic                   rom_ack,
	input  logic [`SMS_ROM_AW-1:0] rom_raddr,
	output logic [`SMS_ROM_AW-1:0] rom_raddr_out,
	output logic [`SMS_ROM_AW-1:0] cart_mask,
	output logic                   gg,
	output cheat_code_t            cheat,
	output logic                   cheat_valid,
	input  logic                   img_mounted,
	input  logic                   img_readonly,
	input  logic                   img_nonzero,
	input  logic                   bk_load_level,
	input  logic                   bk_save_level,
	input  logic                   autosave,
	input  logic                   osd_open,
	input  logic                   nvram_we,
	output sd_req_t                sd_req,
	input  logic                   sd_ack,
	output logic                   bk_busy,
	output logic                   bk_loading,
	output logic                   bk_pending,
	output clk_en_t                ce,
	output logic                   sys_reset
);

	logic code_index;
	logic code_dl, cart_dl;

	assign code_index = (host.index == `SMS_CODE_INDEX);
	assign code_dl    = download & code_index;
	assign cart_dl    = download & ~code_index;

	assign sys_reset = reset | cart_dl | bk_loading;   // Core held while image changes

	sms_clk_enables u_ce (
		.clk_sys (clk_sys),
		.reset   (reset),
		.ce      (ce)
	);

	sms_cart_loader u_cart (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.host          (host),
		.cart_dl       (cart_dl),
		.io_wait       (io_wait),
		.rom_wr        (rom_wr),
		.rom_ack       (rom_ack),
		.rom_raddr     (rom_raddr),
		.rom_raddr_out (rom_raddr_out),
		.cart_mask     (cart_mask),
		.gg            (gg)
	);

	sms_cheat_loader u_cheat (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.host        (host),
		.code_dl     (code_dl),
		.cheat       (cheat),
		.cheat_valid (cheat_valid)
	);

	sms_backup_seq u_bk (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.cart_dl       (cart_dl),
		.img_mounted   (img_mounted),
		.img_readonly  (img_readonly),
		.img_nonzero   (img_nonzero),
		.bk_load_level (bk_load_level),
		.bk_save_level (bk_save_level),
		.autosave      (autosave),
		.osd_open      (osd_open),
		.nvram_we      (nvram_we),
		.sd_req        (sd_req),
		.sd_ack        (sd_ack),
		.bk_busy       (bk_busy),
		.bk_loading    (bk_loading),
		.bk_pending    (bk_pending)
	);

endmodule

// ==== sms_backup_seq.sv ====
/*
 * Backup RAM load/save sequencer, SMS_BK_SECTORS sectors per transfer.
 * Triggers are ignored unless a writable image was mounted during download.
 * A trigger arriving while busy is dropped.
 * sd_ack must rise and fall once per sector.
 */
`timescale 1ns/1ps
`include "sms_cfg.svh"

module sms_backup_seq import sms_pkg::*; (
	input  logic    clk_sys,
	input  logic    reset,
	input  logic    cart_dl,
	input  logic    img_mounted,
	input  logic    img_readonly,
	input  logic    img_nonzero,
	input  logic    bk_load_level,
	input  logic    bk_save_level,
	input  logic    autosave,
	input  logic    osd_open,
	input  logic    nvram_we,
	output sd_req_t sd_req,
	input  logic    sd_ack,
	output logic    bk_busy,
	output logic    bk_loading,
	output logic    bk_pending
);

	localparam int LAST_LBA = `SMS_BK_SECTORS - 1;

	bk_state_e state;
	logic      old_dl, old_load, old_save, old_ack;
	logic      bk_ena;
	logic      save_req;
	logic      load_rise, save_rise, auto_load;
	logic      ack_rise, ack_fall;

	assign save_req  = bk_save_level | (bk_pending & osd_open & autosave);
	assign load_rise = bk_ena & bk_load_level & ~old_load;
	assign save_rise = bk_ena & save_req & ~old_save;
	assign auto_load = old_dl & ~cart_dl & img_nonzero & bk_ena;  // Download just ended
	assign ack_rise  = sd_ack & ~old_ack;
	assign ack_fall  = ~sd_ack & old_ack;

	assign bk_busy    = (state != BK_IDLE);
	assign bk_loading = (state == BK_LOAD);

	// ========================================================================
	// Enable and pending flags
	// ========================================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			old_dl     <= 1'b0;
			old_load   <= 1'b0;
			old_save   <= 1'b0;
			old_ack    <= 1'b0;
			bk_ena     <= 1'b0;
			bk_pending <= 1'b0;
		end else begin
			old_dl   <= cart_dl;
			old_load <= bk_load_level & bk_ena;
			old_save <= save_req & bk_ena;
			old_ack  <= sd_ack;

			if (cart_dl & ~old_dl) bk_ena <= 1'b0;
			// Save file is mounted by the end of the download
			if (cart_dl && img_mounted && !img_readonly) bk_ena <= 1'b1;

			if (bk_ena && !osd_open && nvram_we)
				bk_pending <= 1'b1;
			else if (bk_busy)
				bk_pending <= 1'b0;
		end
	end

	// ========================================================================
	// Sector sequencer
	// ========================================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state  <= BK_IDLE;
			sd_req <= '0;
		end else begin
			if (ack_rise) begin
				sd_req.rd <= 1'b0;   // Request taken
				sd_req.wr <= 1'b0;
			end

			case (state)
				BK_IDLE: begin
					if (load_rise | auto_load) begin
						state      <= BK_LOAD;
						sd_req.lba <= '0;
						sd_req.rd  <= 1'b1;
						sd_req.wr  <= 1'b0;
					end else if (save_rise) begin
						state      <= BK_SAVE;
						sd_req.lba <= '0;
						sd_req.rd  <= 1'b0;
						sd_req.wr  <= 1'b1;
					end
				end
				BK_LOAD, BK_SAVE: begin
					if (ack_fall) begin
						if (sd_req.lba == LAST_LBA[`SMS_BK_LBA_W-1:0]) begin
							state <= BK_IDLE;
						end else begin
							sd_req.lba <= sd_req.lba + 1'b1;
							sd_req.rd  <= (state == BK_LOAD);
							sd_req.wr  <= (state == BK_SAVE);
						end
					end
				end
				default: state <= BK_IDLE;
			endcase
		end
	end

endmodule

// ==== sms_cheat_loader.sv ====
/*
 * Builds one cheat record from sixteen code download bytes.
 * Low four address bits select field and byte, lowest byte first.
 * cheat is only meaningful while cheat_valid pulses.
 */
`timescale 1ns/1ps
`include "sms_cfg.svh"

module sms_cheat_loader import sms_pkg::*; (
	input  logic        clk_sys,
	input  logic        reset,
	input  host_byte_t  host,
	input  logic        code_dl,
	output cheat_code_t cheat,
	output logic        cheat_valid
);

	logic       code_wr;
	logic [3:0] offs;
	logic [4:0] bpos;   // Bit position of the byte in its field

	assign code_wr = code_dl & host.wr;
	assign offs    = host.addr[3:0];
	assign bpos    = {offs[1:0], 3'b000};

	always_ff @(posedge clk_sys) begin
		if (code_wr) begin
			case (offs[3:2])
				2'd0: cheat.flags[bpos +: 8]   <= host.data;
				2'd1: cheat.addr[bpos +: 8]    <= host.data;
				2'd2: cheat.compare[bpos +: 8] <= host.data;
				2'd3: cheat.replace[bpos +: 8] <= host.data;
				default: ;
			endcase
		end
	end

	// Record complete after the last byte
	always_ff @(posedge clk_sys) begin
		if (reset)
			cheat_valid <= 1'b0;
		else
			cheat_valid <= code_wr && (offs == `SMS_CODE_LAST);
	end

endmodule

// ==== sms_cart_loader.sv ====
/*
 * Cartridge download into external ROM through a toggle request/ack pair.
 * The host must hold off further writes while io_wait is high.
 * Write address restarts at 0 on each new download.
 * cart_mask assumes the image is written in ascending address order.
 */
`timescale 1ns/1ps
`include "sms_cfg.svh"

module sms_cart_loader import sms_pkg::*; (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  host_byte_t             host,
	input  logic                   cart_dl,
	output logic                   io_wait,
	output rom_wr_t                rom_wr,
	input  logic                   rom_ack,
	input  logic [`SMS_ROM_AW-1:0] rom_raddr,
	output logic [`SMS_ROM_AW-1:0] rom_raddr_out,
	output logic [`SMS_ROM_AW-1:0] cart_mask,
	output logic                   gg
);

	logic old_dl;
	logic cart_wr;
	logic [`SMS_ROM_AW-1:0] wr_addr;

	assign cart_wr = host.wr & cart_dl;

	// ========================================================================
	// Write handshake
	// ========================================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			old_dl     <= 1'b0;
			io_wait    <= 1'b0;
			rom_wr.req <= 1'b0;
			wr_addr    <= '0;
		end else begin
			old_dl <= cart_dl;

			if (cart_wr) begin
				io_wait    <= 1'b1;
				rom_wr.req <= ~rom_wr.req;  // New request
			end else if (io_wait && (rom_wr.req == rom_ack)) begin
				io_wait <= 1'b0;
				wr_addr <= wr_addr + 1'b1;
			end

			if (cart_dl & ~old_dl)
				wr_addr <= '0;   // Start of image
		end
	end

	always_ff @(posedge clk_sys)
		if (cart_wr) rom_wr.data <= host.data;

	assign rom_wr.addr = wr_addr;

	// ========================================================================
	// Image size mask and Game Gear flag
	// ========================================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cart_mask <= '0;
			gg        <= 1'b0;
		end else if (cart_wr) begin
			if (host.addr[`SMS_ROM_AW-1:0] == '0)
				cart_mask <= '0;
			else
				cart_mask <= cart_mask | host.addr[`SMS_ROM_AW-1:0];
			gg <= (host.index[4:0] == `SMS_GG_INDEX);
		end
	end

	// CPU reads wrap within the image
	assign rom_raddr_out = rom_raddr & cart_mask;

endmodule

// ==== sms_clk_enables.sv ====
/*
 * Clock enables for CPU, VDP, pixel and sound from one modulo-30 counter.
 * All enables are registered and low while reset is high.
 * CPU enable always coincides with a VDP enable.
 */
`timescale 1ns/1ps
`include "sms_cfg.svh"

module sms_clk_enables import sms_pkg::*; (
	input  logic    clk_sys,
	input  logic    reset,
	output clk_en_t ce
);

	logic [`SMS_CE_CNT_W-1:0] cnt;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cnt <= '0;
			ce  <= '0;
		end else begin
			ce.snd <= cnt[0];   // Every other cycle
			ce.cpu <= 1'b0;
			ce.vdp <= 1'b0;
			ce.pix <= 1'b0;

			if (cnt == `SMS_CE_CNT_W'(`SMS_CE_PERIOD - 1))
				cnt <= '0;
			else
				cnt <= cnt + 1'b1;

			// Decoded phases, VDP every 5, pixel every 10, CPU every 15
			case (cnt)
				`SMS_PH_VDP_A: ce.vdp <= 1'b1;
				`SMS_PH_PIX_A: begin
					ce.cpu <= 1'b1;
					ce.vdp <= 1'b1;
					ce.pix <= 1'b1;
				end
				`SMS_PH_VDP_B: ce.vdp <= 1'b1;
				`SMS_PH_PIX_B: begin
					ce.vdp <= 1'b1;
					ce.pix <= 1'b1;
				end
				`SMS_PH_CPU_B: begin
					ce.cpu <= 1'b1;   // Late CPU phase, keeps HCounter timing
					ce.vdp <= 1'b1;
				end
				`SMS_PH_LAST: begin
					ce.vdp <= 1'b1;
					ce.pix <= 1'b1;
				end
				default: ;
			endcase
		end
	end

endmodule

// ==== sms_pkg.sv ====
/*
 * Types shared by the host control blocks.
 * Field widths follow sms_cfg.svh.
 */
`include "sms_cfg.svh"

package sms_pkg;

	// Clock enables, one bit each
	typedef struct packed {
		logic cpu;
		logic vdp;
		logic pix;
		logic snd;
	} clk_en_t;

	// One host download beat
	typedef struct packed {
		logic                     wr;     // Beat valid
		logic [`SMS_IO_AW-1:0]    addr;
		logic [7:0]               data;
		logic [`SMS_IDX_W-1:0]    index;  // Image type
	} host_byte_t;

	// ROM write request, new request on each req toggle
	typedef struct packed {
		logic                     req;
		logic [`SMS_ROM_AW-1:0]   addr;
		logic [7:0]               data;
	} rom_wr_t;

	// Cheat record, all fields little endian
	typedef struct packed {
		logic [31:0] flags;
		logic [31:0] addr;
		logic [31:0] compare;
		logic [31:0] replace;
	} cheat_code_t;

	typedef struct packed {
		logic                     rd;
		logic                     wr;
		logic [`SMS_BK_LBA_W-1:0] lba;
	} sd_req_t;

	typedef enum logic [1:0] {
		BK_IDLE = 2'd0,
		BK_LOAD = 2'd1,
		BK_SAVE = 2'd2
	} bk_state_e;

endpackage

// ==== sms_cfg.svh ====
/*
 * Shared constants of the console host control.
 * Enable phases assume one clk_sys period per counter step.
 * Backup transfers are whole images of SMS_BK_SECTORS sectors.
 */
`ifndef SMS_CFG_SVH
`define SMS_CFG_SVH

// Clock enable pattern
`define SMS_CE_PERIOD   30
`define SMS_CE_CNT_W    5
`define SMS_PH_VDP_A    4       // VDP only
`define SMS_PH_PIX_A    9       // CPU, VDP, pixel
`define SMS_PH_VDP_B    14      // VDP only
`define SMS_PH_PIX_B    19      // VDP, pixel
`define SMS_PH_CPU_B    24      // CPU, VDP
`define SMS_PH_LAST     29      // VDP, pixel, wrap

// Address and index widths
`define SMS_ROM_AW      22
`define SMS_IO_AW       25
`define SMS_IDX_W       8

// Backup RAM
`define SMS_BK_SECTORS  64
`define SMS_BK_LBA_W    6

// Download indices
`define SMS_CODE_INDEX  8'hFF
`define SMS_GG_INDEX    5'd2
`define SMS_CODE_LAST   4'hF    // Offset of the final cheat byte

`endif
